/* build.f */
+incdir+include
hdl/cpu_pkg.sv
hdl/ctrl_if.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/datapath.sv
hdl/riscv_top.sv
bench/tb_riscv_top.sv

/* Bender.yml */
package:
  name: riscv_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/cpu_pkg.sv
      - hdl/ctrl_if.sv
      - hdl/control_unit.sv
      - hdl/reg_file.sv
      - hdl/instr_mem.sv
      - hdl/data_mem.sv
      - hdl/datapath.sv
      - hdl/riscv_top.sv
  - target: test
    files:
      - bench/tb_riscv_top.sv

/* bench/tb_riscv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_top;
    import cpu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        imem_we;
    word_t       imem_addr;
    instr_t      imem_data;
    word_t       pc;
    word_t       a0;

    logic [31:0] prog [64];   // program image, loaded during reset
    int          prog_len;
    logic [31:0] rng = 32'd68283;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    riscv_top UUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .imem_we_i   (imem_we),
        .imem_addr_i (imem_addr),
        .imem_data_i (imem_data),
        .pc_o        (pc),
        .a0_o        (a0)
    );

    always #20 clk = ~clk;   // 40 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return i_type(OP_IMM, imm, rs1, 3'b000, rd);
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp)
        begin
            $display("Fail %s exp=%h got=%h", name, exp, got);
            errors++;
        end
    endtask

    // load prog[] under reset, release, then wait for the final loop
    task automatic run_program(input string name, input logic [31:0] final_pc,
                               output bit reached);
        int          i;
        int          n;
        int          cyc;
        logic [31:0] last_pc;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        n = (prog_len > 16) ? prog_len : 16;   // at least 16 cycles of reset
        for (i = 0; i < n; i++)
        begin
            imem_we   = (i < prog_len);
            imem_addr = i;
            imem_data = (i < prog_len) ? prog[i] : '0;
            @(posedge clk);
            #2;
        end
        imem_we = 1'b0;
        rst_n   = 1'b1;
        last_pc = '1;
        reached = 1'b0;
        for (cyc = 0; cyc < 200 && !reached; cyc++)
        begin
            @(negedge clk);   // pc is settled mid cycle
            reached = (pc === last_pc);   // same address twice means the closing loop
            last_pc = pc;
        end
        if (reached)
            check_value("pc", final_pc, pc);
        else
        begin
            $display("%s: program never reached its end", name);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0)
        begin
            tests_passed++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    task automatic test_arith();
        int          err0;
        int          k;
        bit          reached;
        logic [11:0] i1;
        logic [11:0] i2;
        logic [4:0]  sh1;
        logic [4:0]  sh2;
        logic [31:0] m3;
        logic [31:0] m4;
        logic [31:0] m5;
        logic [31:0] m7;
        logic [31:0] exp;
        err0 = errors;
        for (k = 0; k < 3; k++)
        begin
            rng = xorshift(rng);
            i1  = rng[11:0];
            sh1 = rng[20:16];
            rng = xorshift(rng);
            i2  = rng[11:0];
            sh2 = rng[20:16];
            m3  = sext12(i1) + sext12(i2);
            m4  = sext12(i1) - sext12(i2);
            m5  = m3 & m4;
            m7  = m5 ^ (m3 | m4);
            exp = ((m7 << sh1) ^ (m3 << sh2)) + m5;
            prog_len = 0;
            emit(addi(1, 0, i1));
            emit(addi(2, 0, i2));
            emit(r_type(7'h00, 2, 1, 3'b000, 3));   // add
            emit(r_type(7'h20, 2, 1, 3'b000, 4));   // sub
            emit(r_type(7'h00, 4, 3, 3'b111, 5));   // and
            emit(r_type(7'h00, 4, 3, 3'b110, 6));   // or
            emit(r_type(7'h00, 6, 5, 3'b100, 7));   // xor
            emit(addi(8, 0, {7'b0, sh1}));
            emit(r_type(7'h00, 8, 7, 3'b001, 9));   // sll
            emit(i_type(OP_IMM, {7'b0, sh2}, 3, 3'b001, 11));
            emit(r_type(7'h00, 11, 9, 3'b100, 10));
            emit(r_type(7'h00, 5, 10, 3'b000, 10));   // and result kept apart from or
            emit(j_type(21'd0, 0));
            run_program("arith", 4 * (prog_len - 1), reached);
            if (reached)
                check_value("a0", exp, a0);
        end
        report_test("arith", err0);
    endtask

    task automatic test_memory();
        int          err0;
        bit          reached;
        logic [11:0] whi;
        logic [11:0] wlo;
        logic [11:0] hv;
        logic [11:0] bv;
        logic [31:0] word;
        logic [7:0]  mb [4];
        logic [31:0] exp;
        err0 = errors;
        rng  = xorshift(rng);
        whi  = rng[11:0];
        wlo  = rng[27:16];
        rng  = xorshift(rng);
        hv   = rng[11:0] | 12'h800;    // negative half
        bv   = rng[27:16] | 12'h080;   // negative byte
        // byte model at 0x100 after sw, sh at +2, sb at +1
        word  = (sext12(whi) << 20) + sext12(wlo);
        mb[0] = word[7:0];
        mb[1] = bv[7:0];
        mb[2] = hv[7:0];
        mb[3] = sext12(hv) >> 8;
        exp = {mb[3], mb[2], mb[1], mb[0]} + {{16{mb[3][7]}}, mb[3], mb[2]}
            + {16'b0, mb[1], mb[0]} + {{24{mb[1][7]}}, mb[1]} + {24'b0, mb[3]};
        prog_len = 0;
        emit(addi(1, 0, 12'h100));
        emit(addi(2, 0, whi));
        emit(i_type(OP_IMM, 12'd20, 2, 3'b001, 2));
        emit(addi(2, 2, wlo));
        emit(s_type(12'd0, 2, 1, 3'b010));   // sw
        emit(addi(3, 0, hv));
        emit(s_type(12'd2, 3, 1, 3'b001));   // sh
        emit(addi(4, 0, bv));
        emit(s_type(12'd1, 4, 1, 3'b000));   // sb
        emit(i_type(OP_LOAD, 12'd0, 1, 3'b010, 5));
        emit(i_type(OP_LOAD, 12'd2, 1, 3'b001, 6));
        emit(i_type(OP_LOAD, 12'd0, 1, 3'b101, 7));
        emit(i_type(OP_LOAD, 12'd1, 1, 3'b000, 8));
        emit(i_type(OP_LOAD, 12'd3, 1, 3'b100, 9));
        emit(r_type(7'h00, 6, 5, 3'b000, 10));
        emit(r_type(7'h00, 7, 10, 3'b000, 10));
        emit(r_type(7'h00, 8, 10, 3'b000, 10));
        emit(r_type(7'h00, 9, 10, 3'b000, 10));
        emit(j_type(21'd0, 0));
        run_program("memory", 4 * (prog_len - 1), reached);
        if (reached)
            check_value("a0", exp, a0);
        report_test("memory", err0);
    endtask

    task automatic test_branch();
        int          err0;
        bit          reached;
        logic [11:0] v1;
        logic [11:0] v2;
        logic [11:0] v3;
        logic [31:0] exp;
        err0 = errors;
        v1   = 12'd5;
        v2   = 12'd5;
        v3   = 12'd7;
        exp  = 2 + 16 + 64;   // always on the path
        if (v1 != v2)
            exp = exp + 1;
        if (v1 != v3)
            exp = exp + 4;
        if (v1 == v3)
            exp = exp + 8;
        if (v1 == v2)
            exp = exp + 32;
        prog_len = 0;
        emit(addi(1, 0, v1));
        emit(addi(2, 0, v2));
        emit(addi(3, 0, v3));
        emit(addi(10, 0, 12'd0));
        emit(b_type(13'd8, 2, 1, 3'b000));   // beq taken
        emit(addi(10, 10, 12'd1));
        emit(addi(10, 10, 12'd2));
        emit(b_type(13'd8, 3, 1, 3'b000));   // beq not taken
        emit(addi(10, 10, 12'd4));
        emit(b_type(13'd8, 3, 1, 3'b001));   // bne taken
        emit(addi(10, 10, 12'd8));
        emit(addi(10, 10, 12'd16));
        emit(b_type(13'd8, 2, 1, 3'b001));   // bne not taken
        emit(addi(10, 10, 12'd32));
        emit(addi(10, 10, 12'd64));
        emit(j_type(21'd0, 0));
        run_program("branch", 4 * (prog_len - 1), reached);
        if (reached)
            check_value("a0", exp, a0);
        report_test("branch", err0);
    endtask

    task automatic test_jump();
        int          err0;
        bit          reached;
        logic [31:0] link;
        err0 = errors;
        link = 32'd4 + 32'd4;   // jal sits at 0x4
        prog_len = 0;
        emit(addi(5, 0, 12'd1));
        emit(j_type(21'd16, 1));                        // to 0x14
        emit(addi(10, 1, 12'd0));                       // return point
        emit(j_type(21'd0, 0));                         // final loop
        emit(addi(10, 0, 12'd99));                      // skipped
        emit(i_type(OP_JALR, 12'd1, 1, 3'b000, 0));     // bit 0 cleared
        run_program("jump", link + 32'd4, reached);
        if (reached)
            check_value("a0", link, a0);
        report_test("jump", err0);
    endtask

    task automatic test_zero_unknown();
        int          err0;
        bit          reached;
        logic [11:0] val;
        err0 = errors;
        prog_len = 0;
        emit(addi(10, 0, 12'h055));
        emit(addi(0, 0, 12'h07b));
        emit(r_type(7'h00, 10, 10, 3'b000, 0));
        emit(r_type(7'h00, 0, 0, 3'b000, 10));   // mv a0, x0
        emit(j_type(21'd0, 0));
        run_program("zero", 4 * (prog_len - 1), reached);
        if (reached)
            check_value("a0", 32'd0, a0);
        rng = xorshift(rng);
        val = rng[11:0];
        prog_len = 0;
        emit(addi(10, 0, val));
        emit(32'hffff_ffff);
        emit(32'h0000_0577);   // opcode 0x77 with rd = a0
        emit(j_type(21'd0, 0));
        run_program("unknown", 4 * (prog_len - 1), reached);
        if (reached)
            check_value("a0", sext12(val), a0);
        report_test("zero/unknown", err0);
    endtask

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_arith();
        test_memory();
        test_branch();
        test_jump();
        test_zero_unknown();
        $display("tests passed=%0d failed=%0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/riscv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_top (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            imem_we_i,
    input  cpu_pkg::word_t  imem_addr_i,
    input  cpu_pkg::instr_t imem_data_i,
    output cpu_pkg::word_t  pc_o,
    output cpu_pkg::word_t  a0_o
);
    import cpu_pkg::*;

    instr_t instr;
    logic   zero;
    word_t  alu_result;
    word_t  mem_wdata;
    word_t  mem_rdata;

    ctrl_if ctrl_bus ();

    control_unit u_control_unit (
        .instr_i (instr),
        .zero_i  (zero),
        .ctrl    (ctrl_bus.decoder)
    );

    datapath u_datapath (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl         (ctrl_bus.datapath),
        .instr_i      (instr),
        .mem_rdata_i  (mem_rdata),
        .pc_o         (pc_o),
        .alu_result_o (alu_result),
        .mem_wdata_o  (mem_wdata),
        .zero_o       (zero),
        .a0_o         (a0_o)
    );

    instr_mem u_instr_mem (
        .clk_i       (clk_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .pc_i        (pc_o),
        .instr_o     (instr)
    );

    // store and load kinds go straight from the decoded control
    data_mem u_data_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .addr_i  (alu_result),
        .wdata_i (mem_wdata),
        .store_i (ctrl_bus.mem_write),
        .load_i  (ctrl_bus.reg_write),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

/* hdl/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module datapath (
    input  logic            clk_i,
    input  logic            rst_n_i,
    ctrl_if.datapath        ctrl,
    input  cpu_pkg::instr_t instr_i,
    input  cpu_pkg::word_t  mem_rdata_i,
    output cpu_pkg::word_t  pc_o,
    output cpu_pkg::word_t  alu_result_o,
    output cpu_pkg::word_t  mem_wdata_o,
    output logic            zero_o,
    output cpu_pkg::word_t  a0_o
);
    import cpu_pkg::*;

    localparam int SHAMT_W = $clog2(`CPU_XLEN);

    word_t pc_q;
    word_t pc_next;
    word_t pc_plus4;
    word_t pc_target;
    word_t imm_ext;
    word_t rd1;
    word_t rd2;
    word_t src_b;
    word_t alu_res;
    word_t result;

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ra1_i   (instr_i[19:15]),
        .ra2_i   (instr_i[24:20]),
        .wa_i    (instr_i[11:7]),
        .we_i    (ctrl.reg_write != LD_NONE),
        .wd_i    (result),
        .rd1_o   (rd1),
        .rd2_o   (rd2),
        .a0_o    (a0_o)
    );

    always_comb
    begin
        case (ctrl.imm_src)
            IMM_S:   imm_ext = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm_ext = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_J:   imm_ext = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                instr_i[20], instr_i[30:21], 1'b0};
            default: imm_ext = {{20{instr_i[31]}}, instr_i[31:20]};   // I type
        endcase
    end

    assign src_b = ctrl.alu_src ? imm_ext : rd2;

    always_comb
    begin
        case (ctrl.alu_ctrl)
            ALU_SUB: alu_res = rd1 - src_b;
            ALU_AND: alu_res = rd1 & src_b;
            ALU_OR:  alu_res = rd1 | src_b;
            ALU_XOR: alu_res = rd1 ^ src_b;
            ALU_SLL: alu_res = rd1 << src_b[SHAMT_W-1:0];
            default: alu_res = rd1 + src_b;
        endcase
    end

    assign zero_o = (alu_res == '0);   // beq/bne compare via sub

    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + imm_ext;

    always_comb
    begin
        case (ctrl.result_src)
            RES_MEM: result = mem_rdata_i;
            RES_PC4: result = pc_plus4;   // link address
            default: result = alu_res;
        endcase
    end

    always_comb
    begin
        case (ctrl.pc_src)
            PC_IMM:  pc_next = pc_target;
            PC_ALU:  pc_next = {alu_res[`CPU_XLEN-1:1], 1'b0};
            default: pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            pc_q <= '0;
        else
            pc_q <= pc_next;
    end

    assign pc_o         = pc_q;
    assign alu_result_o = alu_res;
    assign mem_wdata_o  = rd2;

endmodule

`default_nettype wire

/* hdl/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module data_mem (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  cpu_pkg::word_t       addr_i,
    input  cpu_pkg::word_t       wdata_i,
    input  cpu_pkg::store_kind_t store_i,
    input  cpu_pkg::load_kind_t  load_i,
    output cpu_pkg::word_t       rdata_o
);
    import cpu_pkg::*;

    localparam int AW = $clog2(`CPU_DMEM_DEPTH);

    logic [7:0]    mem [`CPU_DMEM_DEPTH];
    logic [AW-1:0] idx0;
    logic [AW-1:0] idx1;
    logic [AW-1:0] idx2;
    logic [AW-1:0] idx3;
    word_t         raw;

    assign idx0 = addr_i[AW-1:0];
    assign idx1 = idx0 + AW'(1);
    assign idx2 = idx0 + AW'(2);
    assign idx3 = idx0 + AW'(3);

    // little endian, lowest byte at addr_i
    assign raw = {mem[idx3], mem[idx2], mem[idx1], mem[idx0]};

    always_ff @(posedge clk_i)
    begin
        if (rst_n_i)
        begin
            case (store_i)
                ST_WORD:
                begin
                    mem[idx0] <= wdata_i[7:0];
                    mem[idx1] <= wdata_i[15:8];
                    mem[idx2] <= wdata_i[23:16];
                    mem[idx3] <= wdata_i[31:24];
                end
                ST_HALF:
                begin
                    mem[idx0] <= wdata_i[7:0];
                    mem[idx1] <= wdata_i[15:8];
                end
                ST_BYTE:
                begin
                    mem[idx0] <= wdata_i[7:0];
                end
                default:
                begin
                end
            endcase
        end
    end

    always_comb
    begin
        case (load_i)
            LD_HALF:  rdata_o = {{16{raw[15]}}, raw[15:0]};
            LD_BYTE:  rdata_o = {{24{raw[7]}}, raw[7:0]};
            LD_HALFU: rdata_o = {16'b0, raw[15:0]};
            LD_BYTEU: rdata_o = {24'b0, raw[7:0]};
            default:  rdata_o = raw;   // lw
        endcase
    end

endmodule

`default_nettype wire

/* hdl/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module instr_mem (
    input  logic            clk_i,
    input  logic            imem_we_i,
    input  cpu_pkg::word_t  imem_addr_i,   // word index, not a byte address
    input  cpu_pkg::instr_t imem_data_i,
    input  cpu_pkg::word_t  pc_i,
    output cpu_pkg::instr_t instr_o
);
    import cpu_pkg::*;

    localparam int AW = $clog2(`CPU_IMEM_DEPTH);

    // all-zero word decodes as a no-op
    instr_t rom [`CPU_IMEM_DEPTH] = '{default: '0};

    always_ff @(posedge clk_i)
    begin
        if (imem_we_i)
            rom[imem_addr_i[AW-1:0]] <= imem_data_i;
    end

    assign instr_o = rom[pc_i[AW+1:2]];

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  cpu_pkg::reg_addr_t ra1_i,
    input  cpu_pkg::reg_addr_t ra2_i,
    input  cpu_pkg::reg_addr_t wa_i,
    input  logic               we_i,
    input  cpu_pkg::word_t     wd_i,
    output cpu_pkg::word_t     rd1_o,
    output cpu_pkg::word_t     rd2_o,
    output cpu_pkg::word_t     a0_o
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we_i && (wa_i != '0))   // x0 never written
        begin
            regs[wa_i] <= wd_i;
        end
    end

    assign rd1_o = regs[ra1_i];
    assign rd2_o = regs[ra2_i];
    assign a0_o  = regs[10];

endmodule

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  cpu_pkg::instr_t instr_i,
    input  logic            zero_i,
    ctrl_if.decoder         ctrl
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7_5 = instr_i[30];   // selects sub over add

    always_comb
    begin
        // no-op unless an opcode below matches
        ctrl.reg_write  = LD_NONE;
        ctrl.mem_write  = ST_NONE;
        ctrl.result_src = RES_ALU;
        ctrl.alu_ctrl   = ALU_ADD;
        ctrl.alu_src    = 1'b1;
        ctrl.imm_src    = IMM_I;
        ctrl.pc_src     = PC_PLUS4;

        case (opcode)
            OP_LOAD:
            begin
                ctrl.result_src = RES_MEM;
                case (funct3)
                    3'b000:  ctrl.reg_write = LD_BYTE;
                    3'b001:  ctrl.reg_write = LD_HALF;
                    3'b010:  ctrl.reg_write = LD_WORD;
                    3'b100:  ctrl.reg_write = LD_BYTEU;
                    3'b101:  ctrl.reg_write = LD_HALFU;
                    default: ctrl.reg_write = LD_NONE;
                endcase
            end
            OP_STORE:
            begin
                ctrl.imm_src = IMM_S;
                case (funct3)
                    3'b000:  ctrl.mem_write = ST_BYTE;
                    3'b001:  ctrl.mem_write = ST_HALF;
                    3'b010:  ctrl.mem_write = ST_WORD;
                    default: ctrl.mem_write = ST_NONE;
                endcase
            end
            OP_REG:
            begin
                ctrl.reg_write = LD_WORD;
                ctrl.alu_src   = 1'b0;
                case (funct3)
                    3'b000:  ctrl.alu_ctrl = funct7_5 ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.alu_ctrl = ALU_SLL;
                    3'b100:  ctrl.alu_ctrl = ALU_XOR;
                    3'b110:  ctrl.alu_ctrl = ALU_OR;
                    3'b111:  ctrl.alu_ctrl = ALU_AND;
                    default: ctrl.alu_ctrl = ALU_ADD;
                endcase
            end
            OP_IMM:
            begin
                ctrl.reg_write = LD_WORD;
                ctrl.alu_ctrl  = (funct3 == 3'b001) ? ALU_SLL : ALU_ADD;   // slli or addi
            end
            OP_BRANCH:
            begin
                ctrl.alu_src  = 1'b0;
                ctrl.alu_ctrl = ALU_SUB;
                ctrl.imm_src  = IMM_B;
                case (funct3)
                    3'b000:  ctrl.pc_src = zero_i ? PC_IMM : PC_PLUS4;   // beq
                    3'b001:  ctrl.pc_src = zero_i ? PC_PLUS4 : PC_IMM;   // bne
                    default: ctrl.pc_src = PC_PLUS4;
                endcase
            end
            OP_JAL:
            begin
                ctrl.reg_write  = LD_WORD;
                ctrl.result_src = RES_PC4;
                ctrl.imm_src    = IMM_J;
                ctrl.pc_src     = PC_IMM;
            end
            OP_JALR:
            begin
                ctrl.reg_write  = LD_WORD;
                ctrl.result_src = RES_PC4;
                ctrl.pc_src     = PC_ALU;   // rs1 + imm from the ALU
            end
            default:
            begin
                ctrl.reg_write = LD_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded control, valid for the whole cycle
interface ctrl_if;
    import cpu_pkg::*;

    load_kind_t  reg_write;   // 000 means no register write
    store_kind_t mem_write;
    result_src_t result_src;
    alu_op_t     alu_ctrl;
    logic        alu_src;     // 1 selects the immediate
    imm_src_t    imm_src;
    pc_src_t     pc_src;

    modport decoder (
        output reg_write, mem_write, result_src, alu_ctrl, alu_src, imm_src, pc_src
    );

    modport datapath (
        input reg_write, mem_write, result_src, alu_ctrl, alu_src, imm_src, pc_src
    );

endinterface

`default_nettype wire

/* hdl/cpu_pkg.sv */
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [31:0]          instr_t;
    typedef logic [4:0]           reg_addr_t;
    typedef logic [2:0]           alu_op_t;
    typedef logic [1:0]           imm_src_t;
    typedef logic [1:0]           result_src_t;
    typedef logic [1:0]           pc_src_t;
    typedef logic [2:0]           load_kind_t;   // also marks plain register writes
    typedef logic [1:0]           store_kind_t;

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam alu_op_t ALU_ADD = 3'b000;
    localparam alu_op_t ALU_SUB = 3'b001;
    localparam alu_op_t ALU_AND = 3'b010;
    localparam alu_op_t ALU_OR  = 3'b011;
    localparam alu_op_t ALU_XOR = 3'b100;
    localparam alu_op_t ALU_SLL = 3'b101;

    localparam imm_src_t IMM_I = 2'b00;
    localparam imm_src_t IMM_S = 2'b01;
    localparam imm_src_t IMM_B = 2'b10;
    localparam imm_src_t IMM_J = 2'b11;

    localparam result_src_t RES_ALU = 2'b00;
    localparam result_src_t RES_MEM = 2'b01;
    localparam result_src_t RES_PC4 = 2'b10;

    localparam pc_src_t PC_PLUS4 = 2'b00;
    localparam pc_src_t PC_IMM   = 2'b01;
    localparam pc_src_t PC_ALU   = 2'b10;   // jalr target

    localparam load_kind_t LD_NONE  = 3'b000;
    localparam load_kind_t LD_WORD  = 3'b001;
    localparam load_kind_t LD_HALF  = 3'b010;
    localparam load_kind_t LD_BYTE  = 3'b011;
    localparam load_kind_t LD_HALFU = 3'b110;
    localparam load_kind_t LD_BYTEU = 3'b111;

    localparam store_kind_t ST_NONE = 2'b00;
    localparam store_kind_t ST_WORD = 2'b01;
    localparam store_kind_t ST_HALF = 2'b10;
    localparam store_kind_t ST_BYTE = 2'b11;

endpackage

`default_nettype wire

/* include/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path width
`define CPU_XLEN 32

// instruction memory size in words
`define CPU_IMEM_DEPTH 256

// data memory size in bytes
`define CPU_DMEM_DEPTH 1024

`endif
